//--- common/lite_demux_pkg.sv
/*
  Shared widths, limits and channel types of the AXI4-Lite demux.
  Modules pull these in with a wildcard import inside the body
  and use scoped names for their port types.
*/
package lite_demux_pkg;

  // ------------------------------
  // bus widths
  // ------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;  // one strobe per byte

  // ------------------------------
  // port limits
  // ------------------------------
  localparam int MAX_PORTS = 8;  // upper bound for NumPorts
  localparam int SEL_W     = 3;  // enough to index MAX_PORTS

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [STRB_W-1:0]    strb_t;
  typedef logic [SEL_W-1:0]     sel_t;
  typedef logic [1:0]           resp_t;
  typedef logic [MAX_PORTS-1:0] port_vec_t;  // one bit per possible port

  // axi response codes
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // one-hot of a port index, bits at or above num_ports stay low
  function automatic port_vec_t sel_onehot(sel_t sel, int num_ports);
    port_vec_t hit;
    hit = '0;
    for (int i = 0; i < MAX_PORTS; i++) begin
      hit[i] = (i < num_ports) && (sel == sel_t'(i));
    end
    return hit;
  endfunction

endpackage

//--- src/spill_stage.sv
/*
  Two-entry valid/ready register slice.
  Cuts both the valid and the ready path between its sides while
  keeping full throughput and order. Used on the AW and AR requests.
*/
`timescale 1ns/1ps

module spill_stage #(
  parameter int Width = 8
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);

  logic [Width-1:0] a_data_q;  // input side entry
  logic [Width-1:0] b_data_q;  // overflow entry, older than a
  logic             a_full_q;
  logic             b_full_q;
  logic             a_fill;
  logic             a_drain;
  logic             b_fill;
  logic             b_drain;

  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;  // a leaves when b is empty
  assign b_fill  = a_drain & ~ready_i;    // parked in b on a stall
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;  // refill wins over drain
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  // payload only
  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  assign ready_o = ~a_full_q | ~b_full_q;  // any entry free
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;  // oldest first

endmodule

//--- src/sel_fifo.sv
/*
  Small circular FIFO of port indices.
  Keeps the order of requests so responses can be steered back.
  data_o shows the head entry; push when full and pop when empty
  have no effect.
*/
`timescale 1ns/1ps

module sel_fifo #(
  parameter int Depth = 4
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 push_i,
  input  lite_demux_pkg::sel_t data_i,
  input  logic                 pop_i,
  output lite_demux_pkg::sel_t data_o,
  output logic                 full_o,
  output logic                 empty_o
);
  import lite_demux_pkg::*;

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  sel_t            mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  // wrap at Depth, not at a power of two
  function automatic logic [PtrW-1:0] ptr_next(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + PtrW'(1);
  endfunction

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];  // head entry

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + CntW'(1);
        2'b01:   count_q <= count_q - CntW'(1);
        default: count_q <= count_q;  // idle or push+pop
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- write_path/aw_route.sv
/*
  AW steering towards the selected downstream port.
  The port index goes into the W select FIFO on the first cycle the
  request is shown; a lock then holds the valid up without a second
  push until the port accepts.
*/
`timescale 1ns/1ps

module aw_route #(
  parameter int NumPorts = 4
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      aw_valid_i,
  output logic                      aw_ready_o,
  input  lite_demux_pkg::sel_t      aw_sel_i,
  output lite_demux_pkg::port_vec_t m_aw_valid_o,
  input  lite_demux_pkg::port_vec_t m_aw_ready_i,
  output logic                      w_sel_push_o,
  input  logic                      w_sel_full_i
);
  import lite_demux_pkg::*;

  logic      lock_q;       // index already pushed, valid held
  logic      lock_d;
  logic      drive_valid;  // request shown downstream this cycle
  logic      port_ready;
  port_vec_t port_hit;

  assign port_hit   = sel_onehot(aw_sel_i, NumPorts);
  assign port_ready = |(port_hit & m_aw_ready_i);

  // ------------------------------
  // handshake control
  // ------------------------------
  always_comb begin
    lock_d       = lock_q;
    drive_valid  = 1'b0;
    aw_ready_o   = 1'b0;
    w_sel_push_o = 1'b0;
    if (lock_q) begin
      drive_valid = 1'b1;  // keep showing the pending request
      if (port_ready) begin
        aw_ready_o = 1'b1;
        lock_d     = 1'b0;
      end
    end else if (aw_valid_i && !w_sel_full_i) begin
      // new request, record where its W beat goes
      w_sel_push_o = 1'b1;
      drive_valid  = 1'b1;
      if (port_ready) begin
        aw_ready_o = 1'b1;
      end else begin
        lock_d = 1'b1;  // no second push next cycle
      end
    end
  end

  assign m_aw_valid_o = {MAX_PORTS{drive_valid}} & port_hit;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

endmodule

//--- write_path/wb_route.sv
/*
  W and B steering.
  A W beat goes only to the port at the head of the W select FIFO,
  and only while the B select FIFO has room. Each W transfer hands
  the index to the B FIFO, whose head picks the B response to return.
*/
`timescale 1ns/1ps

module wb_route #(
  parameter int NumPorts = 4,
  parameter int MaxTrans = 4
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      w_sel_push_i,
  input  lite_demux_pkg::sel_t      w_sel_i,
  output logic                      w_sel_full_o,
  input  logic                      s_w_valid_i,
  output logic                      s_w_ready_o,
  output lite_demux_pkg::port_vec_t m_w_valid_o,
  input  lite_demux_pkg::port_vec_t m_w_ready_i,
  output logic                      s_b_valid_o,
  input  logic                      s_b_ready_i,
  output lite_demux_pkg::resp_t     s_b_resp_o,
  input  lite_demux_pkg::port_vec_t m_b_valid_i,
  output lite_demux_pkg::port_vec_t m_b_ready_o,
  input  lite_demux_pkg::resp_t [lite_demux_pkg::MAX_PORTS-1:0] m_b_resp_i
);
  import lite_demux_pkg::*;

  sel_t      w_sel;    // port owed the next W beat
  sel_t      b_sel;    // port owed the next B response
  logic      w_empty;
  logic      b_full;
  logic      b_empty;
  logic      w_open;   // W beat may go downstream
  logic      w_xfer;
  logic      b_xfer;
  port_vec_t w_hit;
  port_vec_t b_hit;

  sel_fifo #(
    .Depth ( MaxTrans )
  ) i_w_sel_fifo (
    .clk_i   ( clk_i        ),
    .reset_i ( reset_i      ),
    .push_i  ( w_sel_push_i ),
    .data_i  ( w_sel_i      ),
    .pop_i   ( w_xfer       ),
    .data_o  ( w_sel        ),
    .full_o  ( w_sel_full_o ),
    .empty_o ( w_empty      )
  );

  // ------------------------------
  // W channel
  // ------------------------------
  assign w_hit       = sel_onehot(w_sel, NumPorts);
  assign w_open      = ~w_empty & ~b_full;
  assign m_w_valid_o = {MAX_PORTS{w_open & s_w_valid_i}} & w_hit;
  assign s_w_ready_o = w_open & |(w_hit & m_w_ready_i);
  assign w_xfer      = s_w_valid_i & s_w_ready_o;  // pops W, pushes B

  sel_fifo #(
    .Depth ( MaxTrans )
  ) i_b_sel_fifo (
    .clk_i   ( clk_i   ),
    .reset_i ( reset_i ),
    .push_i  ( w_xfer  ),
    .data_i  ( w_sel   ),
    .pop_i   ( b_xfer  ),
    .data_o  ( b_sel   ),
    .full_o  ( b_full  ),
    .empty_o ( b_empty )
  );

  // ------------------------------
  // B channel
  // ------------------------------
  assign b_hit       = sel_onehot(b_sel, NumPorts);
  assign s_b_valid_o = ~b_empty & |(b_hit & m_b_valid_i);
  assign s_b_resp_o  = b_empty ? RESP_OKAY : m_b_resp_i[b_sel];
  assign m_b_ready_o = {MAX_PORTS{~b_empty & s_b_ready_i}} & b_hit;  // head port only
  assign b_xfer      = s_b_valid_o & s_b_ready_i;

endmodule

//--- read_path/ar_r_route.sv
/*
  AR and R steering.
  AR goes to its port while the R select FIFO has room, and the
  index is pushed on acceptance. R is taken from the port at the
  FIFO head, which pops on the upstream R transfer.
*/
`timescale 1ns/1ps

module ar_r_route #(
  parameter int NumPorts = 4,
  parameter int MaxTrans = 4
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      ar_valid_i,
  output logic                      ar_ready_o,
  input  lite_demux_pkg::sel_t      ar_sel_i,
  output lite_demux_pkg::port_vec_t m_ar_valid_o,
  input  lite_demux_pkg::port_vec_t m_ar_ready_i,
  output logic                      s_r_valid_o,
  input  logic                      s_r_ready_i,
  output lite_demux_pkg::data_t     s_r_data_o,
  output lite_demux_pkg::resp_t     s_r_resp_o,
  input  lite_demux_pkg::port_vec_t m_r_valid_i,
  output lite_demux_pkg::port_vec_t m_r_ready_o,
  input  lite_demux_pkg::data_t [lite_demux_pkg::MAX_PORTS-1:0] m_r_data_i,
  input  lite_demux_pkg::resp_t [lite_demux_pkg::MAX_PORTS-1:0] m_r_resp_i
);
  import lite_demux_pkg::*;

  sel_t      r_sel;    // port owed the next R beat
  logic      r_full;
  logic      r_empty;
  logic      ar_xfer;
  logic      r_xfer;
  port_vec_t ar_hit;
  port_vec_t r_hit;

  // ------------------------------
  // AR channel
  // ------------------------------
  assign ar_hit       = sel_onehot(ar_sel_i, NumPorts);
  assign m_ar_valid_o = {MAX_PORTS{ar_valid_i & ~r_full}} & ar_hit;  // stall on full
  assign ar_ready_o   = ~r_full & |(ar_hit & m_ar_ready_i);
  assign ar_xfer      = ar_valid_i & ar_ready_o;

  sel_fifo #(
    .Depth ( MaxTrans )
  ) i_r_sel_fifo (
    .clk_i   ( clk_i    ),
    .reset_i ( reset_i  ),
    .push_i  ( ar_xfer  ),
    .data_i  ( ar_sel_i ),
    .pop_i   ( r_xfer   ),
    .data_o  ( r_sel    ),
    .full_o  ( r_full   ),
    .empty_o ( r_empty  )
  );

  // ------------------------------
  // R channel
  // ------------------------------
  assign r_hit       = sel_onehot(r_sel, NumPorts);
  assign s_r_valid_o = ~r_empty & |(r_hit & m_r_valid_i);
  assign s_r_data_o  = r_empty ? '0 : m_r_data_i[r_sel];
  assign s_r_resp_o  = r_empty ? RESP_OKAY : m_r_resp_i[r_sel];
  assign m_r_ready_o = {MAX_PORTS{~r_empty & s_r_ready_i}} & r_hit;
  assign r_xfer      = s_r_valid_o & s_r_ready_i;  // in request order

endmodule

//--- src/lite_demux.sv
/*
  AXI4-Lite one-to-many demux, top level.
  The upstream master gives a port index with every AW and AR. Both
  requests pass a spill stage, then the routers steer them and return
  B and R in request order. W, B and R have no added latency.
*/
`timescale 1ns/1ps

module lite_demux #(
  parameter int NumPorts = 4,  // 2 to 8
  parameter int MaxTrans = 4   // open transactions per direction
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // upstream
  input  logic                      s_aw_valid_i,
  output logic                      s_aw_ready_o,
  input  lite_demux_pkg::addr_t     s_aw_addr_i,
  input  lite_demux_pkg::sel_t      s_aw_sel_i,    // stable with valid
  input  logic                      s_w_valid_i,
  output logic                      s_w_ready_o,
  input  lite_demux_pkg::data_t     s_w_data_i,
  input  lite_demux_pkg::strb_t     s_w_strb_i,
  output logic                      s_b_valid_o,
  input  logic                      s_b_ready_i,
  output lite_demux_pkg::resp_t     s_b_resp_o,
  input  logic                      s_ar_valid_i,
  output logic                      s_ar_ready_o,
  input  lite_demux_pkg::addr_t     s_ar_addr_i,
  input  lite_demux_pkg::sel_t      s_ar_sel_i,    // stable with valid
  output logic                      s_r_valid_o,
  input  logic                      s_r_ready_i,
  output lite_demux_pkg::data_t     s_r_data_o,
  output lite_demux_pkg::resp_t     s_r_resp_o,
  // downstream, shared payload and per-port handshakes
  output lite_demux_pkg::addr_t     m_aw_addr_o,
  output lite_demux_pkg::port_vec_t m_aw_valid_o,
  input  lite_demux_pkg::port_vec_t m_aw_ready_i,
  output lite_demux_pkg::data_t     m_w_data_o,
  output lite_demux_pkg::strb_t     m_w_strb_o,
  output lite_demux_pkg::port_vec_t m_w_valid_o,
  input  lite_demux_pkg::port_vec_t m_w_ready_i,
  input  lite_demux_pkg::port_vec_t m_b_valid_i,
  output lite_demux_pkg::port_vec_t m_b_ready_o,
  input  lite_demux_pkg::resp_t [lite_demux_pkg::MAX_PORTS-1:0] m_b_resp_i,
  output lite_demux_pkg::addr_t     m_ar_addr_o,
  output lite_demux_pkg::port_vec_t m_ar_valid_o,
  input  lite_demux_pkg::port_vec_t m_ar_ready_i,
  input  lite_demux_pkg::port_vec_t m_r_valid_i,
  output lite_demux_pkg::port_vec_t m_r_ready_o,
  input  lite_demux_pkg::data_t [lite_demux_pkg::MAX_PORTS-1:0] m_r_data_i,
  input  lite_demux_pkg::resp_t [lite_demux_pkg::MAX_PORTS-1:0] m_r_resp_i
);
  import lite_demux_pkg::*;

  localparam int ReqW = ADDR_W + SEL_W;  // address plus port index

  logic            aw_valid;
  logic            aw_ready;
  logic [ReqW-1:0] aw_req;
  sel_t            aw_sel;
  logic            w_sel_push;
  logic            w_sel_full;
  logic            ar_valid;
  logic            ar_ready;
  logic [ReqW-1:0] ar_req;
  sel_t            ar_sel;

  // ------------------------------
  // write path
  // ------------------------------
  spill_stage #(
    .Width ( ReqW )
  ) i_aw_spill (
    .clk_i   ( clk_i                     ),
    .reset_i ( reset_i                   ),
    .valid_i ( s_aw_valid_i              ),
    .ready_o ( s_aw_ready_o              ),
    .data_i  ( {s_aw_addr_i, s_aw_sel_i} ),
    .valid_o ( aw_valid                  ),
    .ready_i ( aw_ready                  ),
    .data_o  ( aw_req                    )
  );

  assign m_aw_addr_o = aw_req[ReqW-1:SEL_W];
  assign aw_sel      = aw_req[SEL_W-1:0];
  assign m_w_data_o  = s_w_data_i;  // W payload shared by all ports
  assign m_w_strb_o  = s_w_strb_i;

  aw_route #(
    .NumPorts ( NumPorts )
  ) i_aw_route (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .aw_valid_i   ( aw_valid     ),
    .aw_ready_o   ( aw_ready     ),
    .aw_sel_i     ( aw_sel       ),
    .m_aw_valid_o ( m_aw_valid_o ),
    .m_aw_ready_i ( m_aw_ready_i ),
    .w_sel_push_o ( w_sel_push   ),
    .w_sel_full_i ( w_sel_full   )
  );

  wb_route #(
    .NumPorts ( NumPorts ),
    .MaxTrans ( MaxTrans )
  ) i_wb_route (
    .clk_i        ( clk_i       ),
    .reset_i      ( reset_i     ),
    .w_sel_push_i ( w_sel_push  ),
    .w_sel_i      ( aw_sel      ),
    .w_sel_full_o ( w_sel_full  ),
    .s_w_valid_i  ( s_w_valid_i ),
    .s_w_ready_o  ( s_w_ready_o ),
    .m_w_valid_o  ( m_w_valid_o ),
    .m_w_ready_i  ( m_w_ready_i ),
    .s_b_valid_o  ( s_b_valid_o ),
    .s_b_ready_i  ( s_b_ready_i ),
    .s_b_resp_o   ( s_b_resp_o  ),
    .m_b_valid_i  ( m_b_valid_i ),
    .m_b_ready_o  ( m_b_ready_o ),
    .m_b_resp_i   ( m_b_resp_i  )
  );

  // ------------------------------
  // read path
  // ------------------------------
  spill_stage #(
    .Width ( ReqW )
  ) i_ar_spill (
    .clk_i   ( clk_i                     ),
    .reset_i ( reset_i                   ),
    .valid_i ( s_ar_valid_i              ),
    .ready_o ( s_ar_ready_o              ),
    .data_i  ( {s_ar_addr_i, s_ar_sel_i} ),
    .valid_o ( ar_valid                  ),
    .ready_i ( ar_ready                  ),
    .data_o  ( ar_req                    )
  );

  assign m_ar_addr_o = ar_req[ReqW-1:SEL_W];
  assign ar_sel      = ar_req[SEL_W-1:0];

  ar_r_route #(
    .NumPorts ( NumPorts ),
    .MaxTrans ( MaxTrans )
  ) i_ar_r_route (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .ar_valid_i   ( ar_valid     ),
    .ar_ready_o   ( ar_ready     ),
    .ar_sel_i     ( ar_sel       ),
    .m_ar_valid_o ( m_ar_valid_o ),
    .m_ar_ready_i ( m_ar_ready_i ),
    .s_r_valid_o  ( s_r_valid_o  ),
    .s_r_ready_i  ( s_r_ready_i  ),
    .s_r_data_o   ( s_r_data_o   ),
    .s_r_resp_o   ( s_r_resp_o   ),
    .m_r_valid_i  ( m_r_valid_i  ),
    .m_r_ready_o  ( m_r_ready_o  ),
    .m_r_data_i   ( m_r_data_i   ),
    .m_r_resp_i   ( m_r_resp_i   )
  );

endmodule

//--- tests/lite_slave_model.sv
/*
  Behavioral AXI4-Lite slave for one downstream port of the demux.
  A 16-word memory that merges writes by strobe and always answers OKAY.
  Words never written read back as the port index in the top byte and
  the word index below. Readies and response valids stall at random.
*/
`timescale 1ns/1ps

module lite_slave_model #(
  parameter int PortIdx = 0
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  lite_demux_pkg::addr_t aw_addr_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  input  lite_demux_pkg::data_t w_data_i,
  input  lite_demux_pkg::strb_t w_strb_i,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  output lite_demux_pkg::resp_t b_resp_o,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  lite_demux_pkg::addr_t ar_addr_i,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output lite_demux_pkg::data_t r_data_o,
  output lite_demux_pkg::resp_t r_resp_o
);
  import lite_demux_pkg::*;

  data_t       mem_q [16];
  logic [15:0] written_q;
  logic        aw_held_q;  // address waiting for its data
  logic        w_held_q;   // data waiting for its address
  logic        r_pend_q;
  logic [3:0]  aw_idx_q;
  logic [3:0]  ar_idx_q;
  data_t       w_data_q;
  strb_t       w_strb_q;

  assign b_resp_o = RESP_OKAY;
  assign r_resp_o = RESP_OKAY;

  // stored word, or the port signature if never written
  function automatic data_t word_value(logic [3:0] idx);
    if (written_q[idx]) begin
      return mem_q[idx];
    end
    return {8'(PortIdx), 24'(idx)};
  endfunction

  always @(posedge clk_i) begin : model_step
    logic  aw_h;
    logic  w_h;
    logic  r_p;
    data_t merged;
    if (reset_i) begin
      written_q  <= '0;
      aw_held_q  <= 1'b0;
      w_held_q   <= 1'b0;
      r_pend_q   <= 1'b0;
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      ar_ready_o <= 1'b0;
      b_valid_o  <= 1'b0;
      r_valid_o  <= 1'b0;
      r_data_o   <= '0;
    end else begin
      aw_h = aw_held_q;
      w_h  = w_held_q;
      r_p  = r_pend_q;
      // ------------------------------
      // write side
      // ------------------------------
      if (aw_valid_i && aw_ready_o) begin
        aw_h = 1'b1;
        aw_idx_q <= aw_addr_i[5:2];  // word index
      end
      if (w_valid_i && w_ready_o) begin  // may come before the address
        w_h = 1'b1;
        w_data_q <= w_data_i;
        w_strb_q <= w_strb_i;
      end
      if (aw_held_q && w_held_q && !b_valid_o && ($urandom % 3 != 0)) begin
        merged = word_value(aw_idx_q);
        for (int b = 0; b < STRB_W; b++) begin
          if (w_strb_q[b]) merged[8*b +: 8] = w_data_q[8*b +: 8];
        end
        mem_q[aw_idx_q]     <= merged;
        written_q[aw_idx_q] <= 1'b1;
        b_valid_o <= 1'b1;
        aw_h = 1'b0;
        w_h  = 1'b0;
      end else if (b_valid_o && b_ready_i) begin
        b_valid_o <= 1'b0;
      end
      // ------------------------------
      // read side
      // ------------------------------
      if (ar_valid_i && ar_ready_o) begin
        r_p = 1'b1;
        ar_idx_q <= ar_addr_i[5:2];
      end
      if (r_pend_q && !r_valid_o && ($urandom % 3 != 0)) begin
        r_valid_o <= 1'b1;
        r_data_o  <= word_value(ar_idx_q);
      end else if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
        r_p = 1'b0;
      end
      aw_held_q  <= aw_h;
      w_held_q   <= w_h;
      r_pend_q   <= r_p;
      aw_ready_o <= !aw_h && ($urandom % 4 != 0);  // random stalls
      w_ready_o  <= !w_h && ($urandom % 4 != 0);
      ar_ready_o <= !r_p && ($urandom % 4 != 0);
    end
  end

endmodule

//--- tests/tb_lite_demux.sv
/*
  Directed testbench of the AXI4-Lite demux with four ports.
  Each port has a behavioral slave with random stalls. Expected read
  data comes from a memory model kept here from the protocol rules.
*/
`timescale 1ns/1ps

module tb_lite_demux;
  import lite_demux_pkg::*;

  localparam int NUM_PORTS = 4;
  localparam int MAX_TRANS = 4;
  localparam int TIMEOUT   = 300;  // cycles per wait

  logic clk_i;
  logic reset_i;
  logic s_aw_valid_i;
  logic s_aw_ready_o;
  logic s_w_valid_i;
  logic s_w_ready_o;
  logic s_b_valid_o;
  logic s_b_ready_i;
  logic s_ar_valid_i;
  logic s_ar_ready_o;
  logic s_r_valid_o;
  logic s_r_ready_i;
  addr_t s_aw_addr_i;
  addr_t s_ar_addr_i;
  addr_t m_aw_addr_o;
  addr_t m_ar_addr_o;
  sel_t  s_aw_sel_i;
  sel_t  s_ar_sel_i;
  data_t s_w_data_i;
  data_t s_r_data_o;
  data_t m_w_data_o;
  strb_t s_w_strb_i;
  strb_t m_w_strb_o;
  resp_t s_b_resp_o;
  resp_t s_r_resp_o;
  port_vec_t m_aw_valid_o;
  port_vec_t m_aw_ready_i;
  port_vec_t m_w_valid_o;
  port_vec_t m_w_ready_i;
  port_vec_t m_b_valid_i;
  port_vec_t m_b_ready_o;
  port_vec_t m_ar_valid_o;
  port_vec_t m_ar_ready_i;
  port_vec_t m_r_valid_i;
  port_vec_t m_r_ready_o;
  resp_t [MAX_PORTS-1:0] m_b_resp_i;
  resp_t [MAX_PORTS-1:0] m_r_resp_i;
  data_t [MAX_PORTS-1:0] m_r_data_i;

  data_t exp_mem [NUM_PORTS][16];  // expected contents per port
  logic  exp_written [NUM_PORTS][16];

  lite_demux #(
    .NumPorts ( NUM_PORTS ),
    .MaxTrans ( MAX_TRANS )
  ) i_lite_demux (.*);

  // ------------------------------
  // slave models with idle ports tied off
  // ------------------------------
  for (genvar p = 0; p < MAX_PORTS; p++) begin : g_port
    if (p < NUM_PORTS) begin : g_model
      lite_slave_model #(
        .PortIdx ( p )
      ) i_slave (
        .clk_i      ( clk_i           ),
        .reset_i    ( reset_i         ),
        .aw_valid_i ( m_aw_valid_o[p] ),
        .aw_ready_o ( m_aw_ready_i[p] ),
        .aw_addr_i  ( m_aw_addr_o     ),
        .w_valid_i  ( m_w_valid_o[p]  ),
        .w_ready_o  ( m_w_ready_i[p]  ),
        .w_data_i   ( m_w_data_o      ),
        .w_strb_i   ( m_w_strb_o      ),
        .b_valid_o  ( m_b_valid_i[p]  ),
        .b_ready_i  ( m_b_ready_o[p]  ),
        .b_resp_o   ( m_b_resp_i[p]   ),
        .ar_valid_i ( m_ar_valid_o[p] ),
        .ar_ready_o ( m_ar_ready_i[p] ),
        .ar_addr_i  ( m_ar_addr_o     ),
        .r_valid_o  ( m_r_valid_i[p]  ),
        .r_ready_i  ( m_r_ready_o[p]  ),
        .r_data_o   ( m_r_data_i[p]   ),
        .r_resp_o   ( m_r_resp_i[p]   )
      );
    end else begin : g_tie
      assign m_aw_ready_i[p] = 1'b0;
      assign m_w_ready_i[p]  = 1'b0;
      assign m_b_valid_i[p]  = 1'b0;
      assign m_b_resp_i[p]   = RESP_OKAY;
      assign m_ar_ready_i[p] = 1'b0;
      assign m_r_valid_i[p]  = 1'b0;
      assign m_r_data_i[p]   = '0;
      assign m_r_resp_i[p]   = RESP_OKAY;
    end
  end

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;  // 40 ns period
  end

  // ------------------------------
  // reporting and compares
  // ------------------------------
  task automatic report_mismatch(string msg);
    $display("** Error at time %0t: %s", $time, msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_timeout(string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_data(data_t got, data_t exp, string what);
    if (got !== exp) report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
  endtask

  task automatic check_resp(resp_t got, resp_t exp, string what);
    if (got !== exp) report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
  endtask

  // ------------------------------
  // expected memory
  // ------------------------------
  function automatic data_t exp_read(int port, int idx);
    if (exp_written[port][idx]) return exp_mem[port][idx];
    return {8'(port), 24'(idx)};  // unwritten signature
  endfunction

  function automatic void apply_write(int port, int idx, data_t data, strb_t strb);
    data_t merged;
    merged = exp_read(port, idx);
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) merged[8*b +: 8] = data[8*b +: 8];
    end
    exp_mem[port][idx]     = merged;
    exp_written[port][idx] = 1'b1;
  endfunction

  // ------------------------------
  // bus tasks start and end 2 ns after a rising edge
  // ------------------------------
  task automatic write_req(int port, int idx, data_t data, strb_t strb);
    logic aw_done;
    logic w_done;
    logic aw_now;
    logic w_now;
    int   cycles;
    aw_done = 1'b0;
    w_done  = 1'b0;
    cycles  = 0;
    s_aw_valid_i = 1'b1;
    s_aw_addr_i  = addr_t'(idx * 4);
    s_aw_sel_i   = sel_t'(port);
    s_w_valid_i  = 1'b1;
    s_w_data_i   = data;
    s_w_strb_i   = strb;
    while (!(aw_done && w_done)) begin
      @(negedge clk_i);
      aw_now = s_aw_valid_i && s_aw_ready_o;
      w_now  = s_w_valid_i && s_w_ready_o;
      @(posedge clk_i);
      #2;
      if (aw_now) begin
        aw_done = 1'b1;
        s_aw_valid_i = 1'b0;
      end
      if (w_now) begin
        w_done = 1'b1;
        s_w_valid_i = 1'b0;
      end
      cycles++;
      if (cycles > TIMEOUT) report_timeout("AW and W handshakes");
    end
    apply_write(port, idx, data, strb);
  endtask

  task automatic collect_b();
    int cycles;
    cycles = 0;
    s_b_ready_i = 1'b1;
    @(negedge clk_i);
    while (!s_b_valid_o) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("a B response");
      @(negedge clk_i);
    end
    check_resp(s_b_resp_o, RESP_OKAY, "B response");
    @(posedge clk_i);
    #2 s_b_ready_i = 1'b0;
  endtask

  task automatic issue_ar(int port, int idx);
    int cycles;
    cycles = 0;
    s_ar_valid_i = 1'b1;
    s_ar_addr_i  = addr_t'(idx * 4);
    s_ar_sel_i   = sel_t'(port);
    @(negedge clk_i);
    while (!s_ar_ready_o) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("the AR handshake");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #2 s_ar_valid_i = 1'b0;
  endtask

  task automatic collect_r(data_t exp, string what);
    int cycles;
    cycles = 0;
    s_r_ready_i = 1'b1;
    @(negedge clk_i);
    while (!s_r_valid_o) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("an R response");
      @(negedge clk_i);
    end
    check_data(s_r_data_o, exp, what);
    check_resp(s_r_resp_o, RESP_OKAY, "R response");
    @(posedge clk_i);
    #2 s_r_ready_i = 1'b0;
  endtask

  task automatic read_check(int port, int idx);
    issue_ar(port, idx);
    collect_r(exp_read(port, idx), $sformatf("read port %0d word %0d", port, idx));
  endtask

  // no response may show up for n cycles
  task automatic expect_quiet(int n);
    repeat (n) begin
      @(negedge clk_i);
      check_flag(s_b_valid_o, 1'b0, "extra B valid");
      check_flag(s_r_valid_o, 1'b0, "extra R valid");
    end
    @(posedge clk_i);
    #2;
  endtask

  // B and R must stay up for n cycles while the upstream readies are low
  task automatic hold_responses(int n);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!(s_b_valid_o && s_r_valid_o)) begin
      cycles++;
      if (cycles > TIMEOUT) report_timeout("waiting B and R responses");
      @(negedge clk_i);
    end
    repeat (n) begin
      @(negedge clk_i);
      check_flag(s_b_valid_o, 1'b1, "B valid with s_b_ready_i low");
      check_flag(s_r_valid_o, 1'b1, "R valid with s_r_ready_i low");
    end
    @(posedge clk_i);
    #2;
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_reset_state();
    @(negedge clk_i);
    check_flag(|m_aw_valid_o, 1'b0, "m_aw_valid_o after reset");
    check_flag(|m_w_valid_o, 1'b0, "m_w_valid_o after reset");
    check_flag(|m_ar_valid_o, 1'b0, "m_ar_valid_o after reset");
    check_flag(s_b_valid_o, 1'b0, "s_b_valid_o after reset");
    check_flag(s_r_valid_o, 1'b0, "s_r_valid_o after reset");
    check_flag(s_aw_ready_o, 1'b1, "s_aw_ready_o after reset");
    check_flag(s_ar_ready_o, 1'b1, "s_ar_ready_o after reset");
    check_flag(s_w_ready_o, 1'b0, "s_w_ready_o after reset");
    @(posedge clk_i);
    #2;
  endtask

  task automatic test_write_routing();
    for (int p = 0; p < NUM_PORTS; p++) begin
      write_req(p, 1, 32'hc0de_0100 + data_t'(p), 4'hf);
      collect_b();
    end
    for (int p = 0; p < NUM_PORTS; p++) read_check(p, 1);
  endtask

  task automatic test_read_routing();
    for (int p = 0; p < NUM_PORTS; p++) read_check(p, 9);  // signature words
  endtask

  task automatic test_ordering();
    for (int k = 0; k < MAX_TRANS; k++) begin
      write_req((k * 3) % NUM_PORTS, 3 + k, 32'h5eed_0000 + data_t'(k * 17), 4'hf);
    end
    repeat (MAX_TRANS) collect_b();
    expect_quiet(10);
    for (int k = 0; k < MAX_TRANS; k++) read_check((k * 3) % NUM_PORTS, 3 + k);
  endtask

  task automatic test_back_pressure();
    data_t exp_a;
    data_t exp_b;
    write_req(1, 7, 32'hb0b0_1111, 4'hf);
    write_req(2, 7, 32'hb0b0_2222, 4'hf);
    exp_a = exp_read(3, 4);
    exp_b = exp_read(0, 4);
    issue_ar(3, 4);
    issue_ar(0, 4);
    hold_responses(20);  // responses pile up behind low readies
    collect_b();
    collect_b();
    collect_r(exp_a, "held read port 3");
    collect_r(exp_b, "held read port 0");
    expect_quiet(10);
    read_check(1, 7);
    read_check(2, 7);
  endtask

  task automatic test_byte_strobes();
    write_req(2, 5, 32'h1122_3344, 4'hf);
    collect_b();
    write_req(2, 5, 32'haabb_ccdd, 4'b0101);
    collect_b();
    read_check(2, 5);
  endtask

  initial begin
    void'($urandom(32'hee7e_5e82));
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int i = 0; i < 16; i++) exp_written[p][i] = 1'b0;
    end
    reset_i      = 1'b1;
    s_aw_valid_i = 1'b0;
    s_aw_addr_i  = '0;
    s_aw_sel_i   = '0;
    s_w_valid_i  = 1'b0;
    s_w_data_i   = '0;
    s_w_strb_i   = '0;
    s_b_ready_i  = 1'b0;
    s_ar_valid_i = 1'b0;
    s_ar_addr_i  = '0;
    s_ar_sel_i   = '0;
    s_r_ready_i  = 1'b0;
    repeat (16) @(posedge clk_i);
    #2 reset_i = 1'b0;
    test_reset_state();
    test_write_routing();
    test_read_routing();
    test_ordering();
    test_back_pressure();
    test_byte_strobes();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- lite_demux.f
common/lite_demux_pkg.sv
src/spill_stage.sv
src/sel_fifo.sv
write_path/aw_route.sv
write_path/wb_route.sv
read_path/ar_r_route.sv
src/lite_demux.sv
tests/lite_slave_model.sv
tests/tb_lite_demux.sv

//--- Makefile
SIM = obj_dir/sim_lite_demux
SRCS = $(shell grep -v '^+' lite_demux.f)

.PHONY: all run clean

all: run

$(SIM): lite_demux.f $(SRCS)
	verilator --binary --timing -f lite_demux.f --top-module tb_lite_demux \
		-o sim_lite_demux

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
